//--- hdl/agen_macros.svh
/*
 * address generation widths and counts
 * register file, segment and immediate sizes used by the stage
 */
`ifndef AGEN_MACROS_SVH
`define AGEN_MACROS_SVH

// general register width
`define AGEN_GPR_W 32

// segment register width
`define AGEN_SEG_W 16

// mmx register width, also the operand width
`define AGEN_MMX_W 64

// immediate field width
`define AGEN_IMM_W 48

// entries in a register bank
`define AGEN_REG_COUNT 8

// segment base is paragraph aligned
`define AGEN_SEG_SHIFT 4

`endif

//--- hdl/agen_pkg.sv
/*
 * address generation types
 * operand kinds, sizes, register snapshot, request and result payloads
 */
`default_nettype none

`include "agen_macros.svh"

package agen_pkg;

    typedef enum logic [2:0] {
        kind_none  = 3'd0,
        kind_reg   = 3'd1,
        kind_seg   = 3'd2,
        kind_mmx   = 3'd3,
        kind_modrm = 3'd4,
        kind_imm   = 3'd5,
        kind_mem   = 3'd6,
        kind_sys   = 3'd7
    } opnd_kind_e;

    // codes 0, 4, 6, 7 select no register
    typedef enum logic [2:0] {
        size_byte  = 3'd1,
        size_word  = 3'd2,
        size_dword = 3'd3,
        size_mmx   = 3'd5
    } op_size_e;

    typedef enum logic [2:0] {
        seg_es = 3'd0,
        seg_cs = 3'd1,
        seg_ss = 3'd2,
        seg_ds = 3'd3,
        seg_fs = 3'd4,
        seg_gs = 3'd5
    } seg_sel_e;

    typedef struct packed {
        logic [15:0] upper;
        logic [7:0]  high;
        logic [7:0]  low;
    } gpr_parts_s;

    // full dword, or AH/AL style byte view
    typedef union packed {
        logic [`AGEN_GPR_W-1:0] dword;
        gpr_parts_s             parts;
    } gpr_word_u;

    typedef struct packed {
        gpr_word_u [`AGEN_REG_COUNT-1:0]                  gpr;
        logic [5:0][`AGEN_SEG_W-1:0]                      seg;  // indexed by seg_sel_e
        logic [`AGEN_REG_COUNT-1:0][`AGEN_MMX_W-1:0]      mmx;
    } reg_state_s;

    typedef logic [`AGEN_REG_COUNT-1:0][`AGEN_MMX_W-1:0] reg_bank_t;

    typedef struct packed {
        op_size_e               size;
        logic                   set_d_flag;
        logic                   clear_d_flag;
        opnd_kind_e             op0;
        opnd_kind_e             op1;
        logic [2:0]             op0_reg;
        logic [2:0]             op1_reg;
        logic [`AGEN_IMM_W-1:0] imm;
        logic [3:0]             alu_op;
        logic [2:0]             flag_0;
        logic [2:0]             flag_1;
        logic [1:0]             stack_op;
        logic [`AGEN_GPR_W-1:0] stack_address;
        seg_sel_e               seg_override;
        logic                   seg_override_valid;
        logic [31:0]            pc;
        logic                   branch_taken;
        logic [15:0]            opcode;
    } agen_req_s;

    typedef struct packed {
        op_size_e               size;
        logic                   set_d_flag;
        logic                   clear_d_flag;
        logic [`AGEN_MMX_W-1:0] op0;
        logic [`AGEN_MMX_W-1:0] op1;
        logic [2:0]             op0_reg;
        logic [2:0]             op1_reg;
        logic                   op0_is_reg;
        logic                   op0_is_segment;
        logic                   op0_is_mmx;
        logic                   op1_is_address;
        logic [`AGEN_IMM_W-1:0] imm;
        logic [3:0]             alu_op;
        logic [2:0]             flag_0;
        logic [2:0]             flag_1;
        logic [1:0]             stack_op;
        logic [`AGEN_GPR_W-1:0] stack_address;
        logic [31:0]            pc;
        logic                   branch_taken;
        logic [15:0]            opcode;
        logic                   to_sys_controller;
    } agen_result_s;

    // segment lookup, codes 6 and 7 read as zero
    function automatic logic [`AGEN_SEG_W-1:0] read_seg(input reg_state_s regs,
                                                         input seg_sel_e sel);
        logic [`AGEN_SEG_W-1:0] value;
        case (sel)
            seg_es, seg_cs, seg_ss, seg_ds, seg_fs, seg_gs: value = regs.seg[sel];
            default: value = '0;
        endcase
        return value;
    endfunction

endpackage

`default_nettype wire

//--- hdl/reg_size_select.sv
/*
 * register size select
 * builds the eight entry register file seen by an operand at the current size
 */
`default_nettype none

`include "agen_macros.svh"

module reg_size_select (
    input  agen_pkg::op_size_e   size,
    input  agen_pkg::reg_state_s regs,
    output agen_pkg::reg_bank_t  bank
);

    localparam int half_count = `AGEN_REG_COUNT / 2;

    agen_pkg::reg_bank_t byte_bank;
    agen_pkg::reg_bank_t word_bank;
    agen_pkg::reg_bank_t dword_bank;

    // byte view: AL CL DL BL then AH CH DH BH
    always_comb begin
        for (int i = 0; i < half_count; i++) begin
            byte_bank[i] = {{(`AGEN_MMX_W - 8){1'b0}}, regs.gpr[i].parts.low};
            byte_bank[i + half_count] = {{(`AGEN_MMX_W - 8){1'b0}},
                                         regs.gpr[i].parts.high};
        end
    end

    always_comb begin
        for (int i = 0; i < `AGEN_REG_COUNT; i++) begin
            word_bank[i] = {{(`AGEN_MMX_W - 16){1'b0}},
                            regs.gpr[i].parts.high, regs.gpr[i].parts.low};
            dword_bank[i] = {{(`AGEN_MMX_W - `AGEN_GPR_W){1'b0}}, regs.gpr[i].dword};
        end
    end

    always_comb begin
        case (size)
            agen_pkg::size_byte:  bank = byte_bank;
            agen_pkg::size_word:  bank = word_bank;
            agen_pkg::size_dword: bank = dword_bank;
            agen_pkg::size_mmx:   bank = regs.mmx;
            // no register at this size
            default:              bank = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/string_addr_gen.sv
/*
 * string address generation
 * ES:EDI destination and DS:ESI source, source segment may be overridden
 */
`default_nettype none

`include "agen_macros.svh"

module string_addr_gen (
    input  agen_pkg::reg_state_s     regs,
    input  agen_pkg::seg_sel_e       seg_override,
    input  logic                     seg_override_valid,
    output logic [`AGEN_GPR_W-1:0]   dst_addr,
    output logic [`AGEN_GPR_W-1:0]   src_addr
);

    localparam int esi_index = 6;
    localparam int edi_index = 7;

    logic [`AGEN_SEG_W-1:0] src_seg;
    logic [`AGEN_GPR_W-1:0] es_base;
    logic [`AGEN_GPR_W-1:0] src_base;

    // destination segment is always ES
    assign es_base = {{(`AGEN_GPR_W - `AGEN_SEG_W){1'b0}},
                      agen_pkg::read_seg(regs, agen_pkg::seg_es)} << `AGEN_SEG_SHIFT;

    always_comb begin
        if (seg_override_valid) begin
            src_seg = agen_pkg::read_seg(regs, seg_override);
        end else begin
            src_seg = agen_pkg::read_seg(regs, agen_pkg::seg_ds);
        end
    end

    assign src_base = {{(`AGEN_GPR_W - `AGEN_SEG_W){1'b0}}, src_seg} << `AGEN_SEG_SHIFT;

    // sums wrap at 32 bits
    assign dst_addr = es_base + regs.gpr[edi_index].dword;
    assign src_addr = src_base + regs.gpr[esi_index].dword;

endmodule

`default_nettype wire

//--- hdl/operand_select.sv
/*
 * operand select
 * picks one 64-bit operand value by operand kind
 */
`default_nettype none

`include "agen_macros.svh"

module operand_select (
    input  agen_pkg::opnd_kind_e      kind,
    input  logic [2:0]                reg_index,
    input  agen_pkg::reg_bank_t       bank,
    input  agen_pkg::reg_state_s      regs,
    input  logic [`AGEN_IMM_W-1:0]    imm,
    input  logic [`AGEN_GPR_W-1:0]    mem_addr,
    output logic [`AGEN_MMX_W-1:0]    operand
);

    logic [`AGEN_SEG_W-1:0] seg_value;

    // reg field doubles as the segment index
    assign seg_value = agen_pkg::read_seg(regs, agen_pkg::seg_sel_e'(reg_index));

    always_comb begin
        case (kind)
            agen_pkg::kind_reg: begin
                // already size selected
                operand = bank[reg_index];
            end
            agen_pkg::kind_seg: begin
                operand = {{(`AGEN_MMX_W - `AGEN_SEG_W){1'b0}}, seg_value};
            end
            agen_pkg::kind_mmx: begin
                // mmx kind ignores the operand size
                operand = regs.mmx[reg_index];
            end
            agen_pkg::kind_imm: begin
                operand = {{(`AGEN_MMX_W - `AGEN_IMM_W){1'b0}}, imm};
            end
            agen_pkg::kind_mem: begin
                operand = {{(`AGEN_MMX_W - `AGEN_GPR_W){1'b0}}, mem_addr};
            end
            // none, modrm and sys carry no value here
            default: begin
                operand = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/agen_flag_decode.sv
/*
 * flag decode and result packing
 * stack pop override on op1, operand flags and decode pass-through
 */
`default_nettype none

`include "agen_macros.svh"

module agen_flag_decode (
    input  agen_pkg::agen_req_s       req,
    input  logic [`AGEN_MMX_W-1:0]    op0,
    input  logic [`AGEN_MMX_W-1:0]    op1,
    output agen_pkg::agen_result_s    result
);

    logic pop;

    // pops read op1 from the stack
    assign pop = req.stack_op[1];

    always_comb begin
        result.size              = req.size;
        result.set_d_flag        = req.set_d_flag;
        result.clear_d_flag      = req.clear_d_flag;
        result.op0               = op0;
        result.op1               = pop ? {{(`AGEN_MMX_W - `AGEN_GPR_W){1'b0}},
                                          req.stack_address} : op1;
        result.op0_reg           = req.op0_reg;
        result.op1_reg           = req.op1_reg;

        result.op0_is_reg        = (req.op0 == agen_pkg::kind_reg);
        result.op0_is_segment    = (req.op0 == agen_pkg::kind_seg);
        // mmx flag follows size, not kind
        result.op0_is_mmx        = (req.size == agen_pkg::size_mmx);
        result.op1_is_address    = (req.op1 == agen_pkg::kind_mem) || pop;

        result.imm               = req.imm;
        result.alu_op            = req.alu_op;
        result.flag_0            = req.flag_0;
        result.flag_1            = req.flag_1;
        result.stack_op          = req.stack_op;
        result.stack_address     = req.stack_address;
        result.pc                = req.pc;
        result.branch_taken      = req.branch_taken;
        result.opcode            = req.opcode;
        result.to_sys_controller = (req.op0 == agen_pkg::kind_sys);
    end

endmodule

`default_nettype wire

//--- hdl/agen_pipestage.sv
/*
 * address generation pipe stage
 * single entry valid/ready register, flush empties it
 */
`default_nettype none

module agen_pipestage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  agen_pkg::agen_result_s  in_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output agen_pkg::agen_result_s  out_data
);

    logic take;

    // accept when empty or the held item leaves this cycle
    assign in_ready = !flush && (!out_valid || out_ready);
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // held value stays put while stalled
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/address_generation_top.sv
/*
 * address generation stage top
 * forms op0 and op1 from the register snapshot and registers the result
 */
`default_nettype none

`include "agen_macros.svh"

module address_generation_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,

    // register access side
    input  logic                    r_valid,
    output logic                    r_ready,
    input  agen_pkg::agen_req_s     r_req,
    input  agen_pkg::reg_state_s    r_regs,

    // memory access side
    output logic                    a_valid,
    input  logic                    a_ready,
    output agen_pkg::agen_result_s  a_result
);

    agen_pkg::reg_bank_t     bank;
    logic [`AGEN_GPR_W-1:0]  dst_addr;
    logic [`AGEN_GPR_W-1:0]  src_addr;
    logic [`AGEN_MMX_W-1:0]  op0_value;
    logic [`AGEN_MMX_W-1:0]  op1_value;
    agen_pkg::agen_result_s  result;

    reg_size_select u_reg_size_select (
        .size (r_req.size),
        .regs (r_regs),
        .bank (bank)
    );

    string_addr_gen u_string_addr_gen (
        .regs               (r_regs),
        .seg_override       (r_req.seg_override),
        .seg_override_valid (r_req.seg_override_valid),
        .dst_addr           (dst_addr),
        .src_addr           (src_addr)
    );

    // op0 strings go to ES:EDI
    operand_select u_op0_select (
        .kind      (r_req.op0),
        .reg_index (r_req.op0_reg),
        .bank      (bank),
        .regs      (r_regs),
        .imm       (r_req.imm),
        .mem_addr  (dst_addr),
        .operand   (op0_value)
    );

    // op1 strings come from DS:ESI or the override
    operand_select u_op1_select (
        .kind      (r_req.op1),
        .reg_index (r_req.op1_reg),
        .bank      (bank),
        .regs      (r_regs),
        .imm       (r_req.imm),
        .mem_addr  (src_addr),
        .operand   (op1_value)
    );

    agen_flag_decode u_flag_decode (
        .req    (r_req),
        .op0    (op0_value),
        .op1    (op1_value),
        .result (result)
    );

    agen_pipestage u_pipestage (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (result),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (a_result)
    );

endmodule

`default_nettype wire

//--- sim/agen_checker.sv
/*
 * address generation handshake checker
 * bound into the stage top, watches reset, back-pressure and flush
 */
`default_nettype none

module agen_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   flush,
    input logic                   r_ready,
    input logic                   a_valid,
    input logic                   a_ready,
    input agen_pkg::agen_result_s a_result
);

    timeunit 1ns;
    timeprecision 1ps;

    // stage is empty the cycle after reset
    a_valid_after_reset: assert property (@(posedge clk) reset |=> !a_valid)
        else $error("a_valid high after reset");

    // a stalled result must not move
    result_stable_stalled: assert property (@(posedge clk) disable iff (reset)
        (a_valid && !a_ready && !flush) |=> (a_valid && $stable(a_result)))
        else $error("a_result changed or dropped while a_ready was low");

    // nothing enters during a flush
    no_accept_on_flush: assert property (@(posedge clk) flush |-> !r_ready)
        else $error("r_ready high during flush");

endmodule

bind address_generation_top agen_checker u_agen_checker (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .r_ready  (r_ready),
    .a_valid  (a_valid),
    .a_ready  (a_ready),
    .a_result (a_result)
);

`default_nettype wire

//--- sim/address_generation_tb.sv
/*
 * address generation stage testbench
 * random requests and register snapshots under flush and back-pressure,
 * results checked in order against a reference model
 */
`default_nettype none

`include "agen_macros.svh"

module address_generation_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_cycles  = 3000;
    localparam int drain_limit = 20;
    localparam int req_w       = $bits(agen_pkg::agen_req_s);
    localparam int regs_w      = $bits(agen_pkg::reg_state_s);
    localparam int req_words   = (req_w + 31) / 32;
    localparam int regs_words  = (regs_w + 31) / 32;

    logic                   clk;
    logic                   reset;
    logic                   flush;
    logic                   r_valid;
    logic                   r_ready;
    agen_pkg::agen_req_s    r_req;
    agen_pkg::reg_state_s   r_regs;
    logic                   a_valid;
    logic                   a_ready;
    agen_pkg::agen_result_s a_result;

    int seed = 26;
    int transfers;
    int flushes;
    int wait_count;
    agen_pkg::agen_result_s exp_q[$];

    address_generation_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_req    (r_req),
        .r_regs   (r_regs),
        .a_valid  (a_valid),
        .a_ready  (a_ready),
        .a_result (a_result)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_operand(input string name, input logic [`AGEN_MMX_W-1:0] got,
                                   input logic [`AGEN_MMX_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_result(input string name, input agen_pkg::agen_result_s got,
                                  input agen_pkg::agen_result_s exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    // codes 6 and 7 name no segment
    function automatic logic [15:0] seg_value(input agen_pkg::reg_state_s regs,
                                              input logic [2:0] idx);
        logic [15:0] value;
        value = '0;
        if (idx < 3'd6) begin
            value = regs.seg[idx];
        end
        return value;
    endfunction

    // indices 4 to 7 at byte size are AH CH DH BH
    function automatic logic [63:0] gpr_view(input logic [2:0] size, input logic [2:0] idx,
                                             input agen_pkg::reg_state_s regs);
        logic [31:0] word;
        logic [63:0] value;
        word  = regs.gpr[idx].dword;
        value = '0;
        case (size)
            3'd1: begin
                word = regs.gpr[idx[1:0]].dword;
                value = idx[2] ? {56'h0, word[15:8]} : {56'h0, word[7:0]};
            end
            3'd2: value = {48'h0, word[15:0]};
            3'd3: value = {32'h0, word};
            3'd5: value = regs.mmx[idx];
            default: value = '0;
        endcase
        return value;
    endfunction

    function automatic logic [63:0] operand_value(input logic [2:0] kind,
                                                  input logic [2:0] idx,
                                                  input agen_pkg::agen_req_s req,
                                                  input agen_pkg::reg_state_s regs,
                                                  input logic [31:0] mem);
        logic [63:0] value;
        case (kind)
            3'd1: value = gpr_view(req.size, idx, regs);
            3'd2: value = {48'h0, seg_value(regs, idx)};
            3'd3: value = regs.mmx[idx];
            3'd5: value = {16'h0, req.imm};
            3'd6: value = {32'h0, mem};
            default: value = '0;
        endcase
        return value;
    endfunction

    function automatic agen_pkg::agen_result_s model_result(input agen_pkg::agen_req_s req,
                                                            input agen_pkg::reg_state_s regs);
        agen_pkg::agen_result_s res;
        logic [31:0] dst;
        logic [31:0] src;
        logic [15:0] src_seg;
        logic [2:0]  op0_code;
        logic [2:0]  op1_code;
        logic [2:0]  size_code;
        logic        pop;
        // ES:EDI destination and DS:ESI or override source
        dst = ({16'h0, regs.seg[0]} << `AGEN_SEG_SHIFT) + regs.gpr[7].dword;
        src_seg = req.seg_override_valid ? seg_value(regs, req.seg_override) : regs.seg[3];
        src = ({16'h0, src_seg} << `AGEN_SEG_SHIFT) + regs.gpr[6].dword;
        op0_code  = req.op0;
        op1_code  = req.op1;
        size_code = req.size;
        pop = req.stack_op[1];
        res = '0;
        res.size              = req.size;
        res.set_d_flag        = req.set_d_flag;
        res.clear_d_flag      = req.clear_d_flag;
        res.op0               = operand_value(req.op0, req.op0_reg, req, regs, dst);
        res.op1               = operand_value(req.op1, req.op1_reg, req, regs, src);
        // a pop takes op1 from the stack
        if (pop) begin
            res.op1 = {32'h0, req.stack_address};
        end
        res.op0_reg           = req.op0_reg;
        res.op1_reg           = req.op1_reg;
        // kind codes 1 reg, 2 seg, 6 memory, 7 sys and size code 5 mmx
        res.op0_is_reg        = (op0_code == 3'd1);
        res.op0_is_segment    = (op0_code == 3'd2);
        res.op0_is_mmx        = (size_code == 3'd5);
        res.op1_is_address    = pop || (op1_code == 3'd6);
        res.imm               = req.imm;
        res.alu_op            = req.alu_op;
        res.flag_0            = req.flag_0;
        res.flag_1            = req.flag_1;
        res.stack_op          = req.stack_op;
        res.stack_address     = req.stack_address;
        res.pc                = req.pc;
        res.branch_taken      = req.branch_taken;
        res.opcode            = req.opcode;
        res.to_sys_controller = (op0_code == 3'd7);
        return res;
    endfunction

    task automatic drive_random();
        logic [req_words*32-1:0]  req_bits;
        logic [regs_words*32-1:0] regs_bits;
        for (int i = 0; i < req_words; i++) begin
            req_bits[i*32 +: 32] = $random(seed);
        end
        for (int i = 0; i < regs_words; i++) begin
            regs_bits[i*32 +: 32] = $random(seed);
        end
        r_req   = agen_pkg::agen_req_s'(req_bits[req_w-1:0]);
        r_regs  = agen_pkg::reg_state_s'(regs_bits[regs_w-1:0]);
        flush   = (($random(seed) % 10) == 0);
        a_ready = (($random(seed) % 4) != 0);
        r_valid = (($random(seed) % 4) != 0);
    endtask

    task automatic drive_idle();
        r_valid = 1'b0;
        flush   = 1'b0;
        a_ready = 1'b1;
    endtask

    // inputs have settled and the next edge takes these values
    task automatic check_cycle();
        agen_pkg::agen_result_s exp;
        compare_bit("a_valid", a_valid, exp_q.size() != 0);
        compare_bit("r_ready", r_ready, !flush && (exp_q.size() == 0 || a_ready));
        if (a_valid && a_ready) begin
            exp = exp_q.pop_front();
            compare_operand("a_result.op0", a_result.op0, exp.op0);
            compare_operand("a_result.op1", a_result.op1, exp.op1);
            compare_result("a_result", a_result, exp);
            transfers++;
        end
        if (flush) begin
            exp_q.delete();
            flushes++;
        end else if (r_valid && r_ready) begin
            exp_q.push_back(model_result(r_req, r_regs));
        end
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        flush   = 1'b0;
        r_valid = 1'b0;
        r_req   = '0;
        r_regs  = '0;
        a_ready = 1'b0;
        transfers = 0;
        flushes   = 0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int cycle = 0; cycle < num_cycles; cycle++) begin
            @(negedge clk);
            drive_random();
            #2;
            check_cycle();
        end

        // let the last result leave
        wait_count = 0;
        while (exp_q.size() != 0 && wait_count < drain_limit) begin
            @(negedge clk);
            drive_idle();
            #2;
            check_cycle();
            wait_count++;
        end

        $display("transfers %0d, flushes %0d", transfers, flushes);
        if (exp_q.size() == 0 && transfers > 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            report_failure("no transfers seen, or results did not drain before the timeout");
        end
    end

endmodule

`default_nettype wire

//--- address_generation_top.f
+incdir+hdl
hdl/agen_pkg.sv
hdl/reg_size_select.sv
hdl/string_addr_gen.sv
hdl/operand_select.sv
hdl/agen_flag_decode.sv
hdl/agen_pipestage.sv
hdl/address_generation_top.sv
sim/agen_checker.sv
sim/address_generation_tb.sv

//--- Makefile
TOP = address_generation_tb

all: run

build:
	verilator --binary --timing --assert -f address_generation_top.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f address_generation_top.f --top-module address_generation_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
